//--- rtl/vls_params.svh
`ifndef VLS_PARAMS_SVH
`define VLS_PARAMS_SVH

// datapath widths
`define VLS_DATA_W      16
`define VLS_ADDR_W      16
`define VLS_VREG_W      4

// bank index bits, upper address bits are dropped so addresses wrap
`define VLS_SPAD_AW     8

// memory opcodes
`define VLS_OP_LOAD     7'b0100111
`define VLS_OP_STORE    7'b0101000

// flow control
`define VLS_CREDITS     4
`define VLS_FIFO_DEPTH  8

`endif

//--- rtl/vls_pkg.sv
`default_nettype none

`include "vls_params.svh"

package vls_pkg;

  // decoded memory operation
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } vls_op_e;

  // one lane of an incoming instruction
  typedef struct packed {
    logic [`VLS_VREG_W-1:0] vd;
    logic [`VLS_ADDR_W-1:0] base;
    logic [7:0]             imm;
    logic [`VLS_DATA_W-1:0] data;
  } vls_lane_t;

  typedef struct packed {
    logic      valid;
    logic [6:0] opcode;
    vls_lane_t a;
    vls_lane_t b;
  } vls_instr_t;

  // issue stage to scratchpad
  typedef struct packed {
    logic                   valid;
    vls_op_e                op;
    logic [`VLS_ADDR_W-1:0] addr_a;
    logic [`VLS_ADDR_W-1:0] addr_b;
    logic [`VLS_DATA_W-1:0] data_a;
    logic [`VLS_DATA_W-1:0] data_b;
  } vls_req_t;

  // scratchpad to writeback
  typedef struct packed {
    logic                   valid;
    vls_op_e                op;
    logic [`VLS_DATA_W-1:0] data_a;
    logic [`VLS_DATA_W-1:0] data_b;
  } vls_resp_t;

  typedef struct packed {
    logic [`VLS_VREG_W-1:0] vd_a;
    logic [`VLS_VREG_W-1:0] vd_b;
  } vls_dest_t;

  typedef struct packed {
    logic                   valid;
    logic [`VLS_VREG_W-1:0] vd_a;
    logic [`VLS_VREG_W-1:0] vd_b;
    logic [`VLS_DATA_W-1:0] data_a;
    logic [`VLS_DATA_W-1:0] data_b;
  } vls_wb_t;

endpackage

`default_nettype wire

//--- rtl/vls_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "vls_params.svh"

module vls_issue import vls_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  vls_instr_t instr,
  output vls_req_t   req,
  output logic       dest_push,
  output vls_dest_t  dest_in
);

  vls_op_e                op;
  logic [`VLS_ADDR_W-1:0] addr_a;
  logic [`VLS_ADDR_W-1:0] addr_b;

  logic                   valid_q;
  vls_op_e                op_q;
  logic [`VLS_ADDR_W-1:0] addr_a_q;
  logic [`VLS_ADDR_W-1:0] addr_b_q;
  logic [`VLS_DATA_W-1:0] data_a_q;
  logic [`VLS_DATA_W-1:0] data_b_q;

  // opcode decode, anything unknown becomes a no-op
  always_comb begin
    case (instr.opcode)
      `VLS_OP_LOAD:  op = OP_LOAD;
      `VLS_OP_STORE: op = OP_STORE;
      default:       op = OP_NONE;
    endcase
  end

  // base plus zero-extended immediate per lane
  assign addr_a = instr.a.base + `VLS_ADDR_W'(instr.a.imm);
  assign addr_b = instr.b.base + `VLS_ADDR_W'(instr.b.imm);

  // load destinations enter the FIFO at the sampling edge
  assign dest_push    = instr.valid && (op == OP_LOAD);
  assign dest_in.vd_a = instr.a.vd;
  assign dest_in.vd_b = instr.b.vd;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr.valid;
    end
  end

  always_ff @(posedge CLK) begin
    op_q     <= op;
    addr_a_q <= addr_a;
    addr_b_q <= addr_b;
    data_a_q <= instr.a.data;
    data_b_q <= instr.b.data;
  end

  assign req = '{
    valid:  valid_q,
    op:     op_q,
    addr_a: addr_a_q,
    addr_b: addr_b_q,
    data_a: data_a_q,
    data_b: data_b_q
  };

endmodule

`default_nettype wire

//--- rtl/vls_dest_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "vls_params.svh"

module vls_dest_fifo import vls_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      push,
  input  vls_dest_t push_data,
  input  logic      pop,
  output vls_dest_t head
);

  localparam int AW = $clog2(`VLS_FIFO_DEPTH);
  localparam logic [AW:0] FULL = `VLS_FIFO_DEPTH;

  vls_dest_t     mem [`VLS_FIFO_DEPTH];
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign do_pop  = pop && (count != '0);
  // a full FIFO still takes a push when the head leaves in the same cycle
  assign do_push = push && ((count != FULL) || do_pop);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // head is read straight out of the array
  assign head = mem[rd_ptr];

endmodule

`default_nettype wire

//--- rtl/vls_scratchpad.sv
`timescale 1ns/1ps
`default_nettype none

`include "vls_params.svh"

module vls_scratchpad import vls_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  vls_req_t  req,
  output vls_resp_t resp
);

  localparam int DEPTH = 1 << `VLS_SPAD_AW;

  logic [`VLS_DATA_W-1:0] bank_a [DEPTH];
  logic [`VLS_DATA_W-1:0] bank_b [DEPTH];

  logic [`VLS_SPAD_AW-1:0] idx_a;
  logic [`VLS_SPAD_AW-1:0] idx_b;

  // stage 1, address registered
  logic                    s1_valid;
  vls_op_e                 s1_op;
  logic [`VLS_SPAD_AW-1:0] s1_idx_a;
  logic [`VLS_SPAD_AW-1:0] s1_idx_b;

  // stage 2, read data registered
  logic                   s2_valid;
  vls_op_e                s2_op;
  logic [`VLS_DATA_W-1:0] s2_data_a;
  logic [`VLS_DATA_W-1:0] s2_data_b;

  // low address bits only, so sums past the bank wrap around
  assign idx_a = req.addr_a[`VLS_SPAD_AW-1:0];
  assign idx_b = req.addr_b[`VLS_SPAD_AW-1:0];

  always_ff @(posedge CLK) begin
    if (req.valid && (req.op == OP_STORE)) begin
      bank_a[idx_a] <= req.data_a;
      bank_b[idx_b] <= req.data_b;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= req.valid;
      s2_valid <= s1_valid;
    end
  end

  // every op goes through both stages so the latency stays fixed
  always_ff @(posedge CLK) begin
    s1_op     <= req.op;
    s1_idx_a  <= idx_a;
    s1_idx_b  <= idx_b;
    s2_op     <= s1_op;
    s2_data_a <= bank_a[s1_idx_a];
    s2_data_b <= bank_b[s1_idx_b];
  end

  assign resp = '{
    valid:  s2_valid,
    op:     s2_op,
    data_a: s2_data_a,
    data_b: s2_data_b
  };

endmodule

`default_nettype wire

//--- rtl/vls_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module vls_writeback import vls_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  vls_resp_t resp,
  input  vls_dest_t dest,
  output logic      dest_pop,
  output vls_wb_t   wb,
  output logic      credit_return
);

  logic    load_hit;
  vls_wb_t last_q;

  assign load_hit = resp.valid && (resp.op == OP_LOAD);

  // FIFO head belongs to this load since loads retire in issue order
  assign dest_pop = load_hit;

  // one credit back per instruction, whatever its op
  assign credit_return = resp.valid;

  // fields hold the previous writeback between loads
  always_comb begin
    wb       = last_q;
    wb.valid = 1'b0;
    if (load_hit) begin
      wb.valid  = 1'b1;
      wb.vd_a   = dest.vd_a;
      wb.vd_b   = dest.vd_b;
      wb.data_a = resp.data_a;
      wb.data_b = resp.data_b;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      last_q <= '0;
    end else if (load_hit) begin
      last_q <= wb;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vls_top.sv
`timescale 1ns/1ps
`default_nettype none

module vls_top import vls_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  vls_instr_t instr,
  output vls_wb_t    wb,
  output logic       credit_return
);

  vls_req_t  req;
  vls_resp_t resp;
  logic      dest_push;
  logic      dest_pop;
  vls_dest_t dest_in;
  vls_dest_t dest_out;

  vls_issue issue_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .instr     (instr),
    .req       (req),
    .dest_push (dest_push),
    .dest_in   (dest_in)
  );

  // load destinations wait here until their data comes back
  vls_dest_fifo dest_fifo_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .push      (dest_push),
    .push_data (dest_in),
    .pop       (dest_pop),
    .head      (dest_out)
  );

  vls_scratchpad spad_i (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .resp (resp)
  );

  vls_writeback wb_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .resp          (resp),
    .dest          (dest_out),
    .dest_pop      (dest_pop),
    .wb            (wb),
    .credit_return (credit_return)
  );

endmodule

`default_nettype wire

//--- testbench/vls_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vls_params.svh"

module vls_tb import vls_pkg::*; ();

  logic       CLK = 1'b0;
  logic       nRST;
  vls_instr_t instr;
  vls_wb_t    wb;
  logic       credit_return;

  logic [15:0]            lfsr = 16'd3;
  logic [`VLS_DATA_W-1:0] shadow_a [256];
  logic [`VLS_DATA_W-1:0] shadow_b [256];
  logic [15:0]            base_a [8];
  logic [15:0]            base_b [8];
  logic [7:0]             imm_a [8];
  logic [7:0]             imm_b [8];
  vls_wb_t                exp_q [$];
  vls_wb_t                exp_wb;
  // valid and load bits of the last three sampled instructions
  logic [2:0]             vpipe;
  logic [2:0]             lpipe;
  int                     credits = `VLS_CREDITS;
  int                     sent = 0;
  int                     returned = 0;
  int                     errors = 0;
  int                     err_mark = 0;
  int                     test_no = 0;
  int                     passed = 0;
  int                     failed = 0;
  bit                     hung = 1'b0;

  vls_top dut_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .instr         (instr),
    .wb            (wb),
    .credit_return (credit_return)
  );

  always #2 CLK = ~CLK;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic vls_lane_t make_lane(input logic [15:0] base, input logic [7:0] imm,
                                          input logic [3:0] vd, input logic [15:0] data);
    return '{vd: vd, base: base, imm: imm, data: data};
  endfunction

  // waits for a credit, updates the shadow model, then drives one instruction
  task automatic send(input logic [6:0] opc, input vls_lane_t la, input vls_lane_t lb);
    int         t;
    logic [7:0] ia;
    logic [7:0] ib;
    vls_wb_t    exp_entry;
    t = 0;
    while (!hung && credits == 0 && t < 50) begin
      @(negedge CLK);
      t++;
    end
    if (!hung && credits == 0) begin
      hung = 1'b1;
      $display("no credit came back within 50 cycles");
    end
    if (!hung) begin
      ia = 8'(la.base + 16'(la.imm));
      ib = 8'(lb.base + 16'(lb.imm));
      if (opc == `VLS_OP_STORE) begin
        shadow_a[ia] = la.data;
        shadow_b[ib] = lb.data;
      end
      if (opc == `VLS_OP_LOAD) begin
        exp_entry.valid  = 1'b1;
        exp_entry.vd_a   = la.vd;
        exp_entry.vd_b   = lb.vd;
        exp_entry.data_a = shadow_a[ia];
        exp_entry.data_b = shadow_b[ib];
        exp_q.push_back(exp_entry);
      end
      instr = '{valid: 1'b1, opcode: opc, a: la, b: lb};
      credits--;
      sent++;
      @(negedge CLK);
      instr.valid = 1'b0;
    end
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (!hung && (credits != `VLS_CREDITS || exp_q.size() != 0) && t < 100) begin
      @(negedge CLK);
      t++;
    end
    if (!hung && (credits != `VLS_CREDITS || exp_q.size() != 0)) begin
      hung = 1'b1;
      $display("pipeline did not drain within 100 cycles");
    end
  endtask

  task automatic end_test(input string name);
    int n;
    drain();
    n = errors - err_mark;
    err_mark = errors;
    test_no++;
    if (n == 0 && !hung) begin
      passed++;
    end else begin
      failed++;
    end
    $display("test %0d %s: %s (%0d errors)", test_no, name,
             (n == 0 && !hung) ? "ok" : "FAILED", n);
  endtask

  always @(posedge CLK) begin
    if (!nRST) begin
      vpipe = '0;
      lpipe = '0;
    end else begin
      assert (credit_return == vpipe[2]) else begin
        errors++;
        $display("Error: credit_return is %h, expected %h", credit_return, vpipe[2]);
      end
      assert (wb.valid == lpipe[2]) else begin
        errors++;
        $display("Error: wb.valid is %h, expected %h", wb.valid, lpipe[2]);
      end
      if (wb.valid && lpipe[2]) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("a writeback came with no load waiting for it");
        end
        if (exp_q.size() != 0) begin
          exp_wb = exp_q.pop_front();
          assert (wb == exp_wb) else begin
            errors++;
            $display("Error: wb is %h, expected %h", wb, exp_wb);
          end
        end
      end
      if (credit_return) begin
        credits++;
        returned++;
      end
      assert (credits >= 0 && credits <= `VLS_CREDITS) else begin
        errors++;
        $display("credit counter left its range at %0d", credits);
      end
      vpipe = {vpipe[1:0], instr.valid};
      lpipe = {lpipe[1:0], instr.valid && (instr.opcode == `VLS_OP_LOAD)};
    end
  end

  initial begin
    logic [6:0] opc;
    logic [2:0] j;
    instr = '0;
    nRST  = 1'b0;
    repeat (16) @(negedge CLK);
    nRST = 1'b1;

    repeat (10) @(negedge CLK);
    end_test("idle after reset");

    for (int k = 0; k < 8; k++) begin
      base_a[k] = rand_bits(16);
      base_b[k] = rand_bits(16);
      imm_a[k]  = 8'(rand_bits(8));
      imm_b[k]  = 8'(rand_bits(8));
      send(`VLS_OP_STORE, make_lane(base_a[k], imm_a[k], 4'd0, rand_bits(16)),
           make_lane(base_b[k], imm_b[k], 4'd0, rand_bits(16)));
    end
    for (int k = 0; k < 8; k++) begin
      send(`VLS_OP_LOAD, make_lane(base_a[k], imm_a[k], 4'(rand_bits(4)), 16'h0),
           make_lane(base_b[k], imm_b[k], 4'(rand_bits(4)), 16'h0));
    end
    end_test("store then load");

    for (int k = 0; k < 12; k++) begin
      send(`VLS_OP_LOAD, make_lane(base_a[k % 8], imm_a[k % 8], 4'(k), 16'h0),
           make_lane(base_b[k % 8], imm_b[k % 8], 4'(15 - k), 16'h0));
    end
    end_test("back-to-back loads");

    for (int k = 0; k < 20; k++) begin
      case (rand_bits(2))
        16'd0:   opc = `VLS_OP_STORE;
        16'd1:   opc = 7'h13;
        default: opc = `VLS_OP_LOAD;
      endcase
      j = 3'(rand_bits(3));
      send(opc, make_lane(base_a[j], imm_a[j], 4'(rand_bits(4)), rand_bits(16)),
           make_lane(base_b[j], imm_b[j], 4'(rand_bits(4)), rand_bits(16)));
    end
    // the last credit is due three cycles after its sampling edge
    repeat (3) @(negedge CLK);
    assert (returned == sent) else begin
      errors++;
      $display("Error: credit_return count is %h, expected %h", returned, sent);
    end
    end_test("credit accounting");

    send(7'h13, make_lane(base_a[0], imm_a[0], 4'd1, 16'hdead),
         make_lane(base_b[0], imm_b[0], 4'd2, 16'hbeef));
    send(`VLS_OP_LOAD, make_lane(base_a[0], imm_a[0], 4'd3, 16'h0),
         make_lane(base_b[0], imm_b[0], 4'd4, 16'h0));
    end_test("non-memory opcode");

    // sums past 255 and past 16 bits land on the low eight bits
    send(`VLS_OP_STORE, make_lane(16'h00f0, 8'h30, 4'd0, 16'h1234),
         make_lane(16'hffff, 8'h05, 4'd0, 16'h5678));
    send(`VLS_OP_LOAD, make_lane(16'h0020, 8'h00, 4'd5, 16'h0),
         make_lane(16'h0004, 8'h00, 4'd6, 16'h0));
    end_test("address wrap");

    $display("%0d tests, %0d ok, %0d failed, %0d errors", passed + failed, passed, failed,
             errors);
    if (failed == 0 && errors == 0 && !hung) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/vls_pkg.sv
rtl/vls_issue.sv
rtl/vls_dest_fifo.sv
rtl/vls_scratchpad.sv
rtl/vls_writeback.sv
rtl/vls_top.sv
testbench/vls_tb.sv

//--- run.sh
#!/bin/sh
# build and run the vls testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module vls_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vvls_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1
